// File: logic/acq_pkg.sv
package acq_pkg;

    // ----------------------------------------------------------------------
    // lane and word widths
    // ----------------------------------------------------------------------
    localparam int N_LANES  = 4;    // all lanes share one cs_n
    localparam int SAMPLE_W = 16;

    typedef logic [SAMPLE_W-1:0]        sample_t;
    typedef logic [N_LANES-1:0]         chan_mask_t;    // bit i -> lane i
    typedef logic [3:0]                 btype_t;
    typedef logic [11:0]                frame_cnt_t;
    typedef logic [7:0]                 byte_t;
    typedef logic [31:0]                cmd_word_t;
    typedef logic [31:0]                stat_word_t;
    typedef logic [$clog2(N_LANES)-1:0] lane_idx_t;
    typedef sample_t [N_LANES-1:0]      lane_samples_t; // one word per lane

    // ----------------------------------------------------------------------
    // run sequencer
    // ----------------------------------------------------------------------
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_CONV,
        SEQ_TRAN,
        SEQ_NEXT
    } seq_state_t;

endpackage

// File: logic/acq_cfg_if.sv
interface acq_cfg_if import acq_pkg::*; #(
    parameter int RAM_AW = 12
);

    chan_mask_t        chan_mask;
    btype_t            btype;
    frame_cnt_t        frames;
    logic              start;       // qualified start, one cycle
    logic              busy;
    frame_cnt_t        frames_done;
    logic [RAM_AW-1:0] wr_ptr;      // next ram write address

    modport regs (
        output chan_mask,
        output btype,
        output frames,
        output start,
        input  busy,
        input  frames_done,
        input  wr_ptr
    );

    modport seq (
        input  frames,
        input  start,
        output busy,
        output frames_done
    );

    modport pack (
        input  chan_mask,
        input  btype,
        input  start,
        output wr_ptr
    );

endinterface

// File: logic/cmd_regs.sv
module cmd_regs import acq_pkg::*; #(
    parameter int RAM_AW = 12
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cmd_wr,
    input  cmd_word_t  cmd_data,
    input  logic       start,
    output stat_word_t status,
    acq_cfg_if.regs    cfg
);

    logic [RAM_AW-1:0] next_addr;

    assign next_addr = cfg.wr_ptr;

    // command fields stay frozen for the whole run
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cfg.chan_mask <= '0;
            cfg.btype     <= '0;
            cfg.frames    <= '0;
        end else if (cmd_wr && !cfg.busy && !cfg.start) begin
            cfg.chan_mask <= cmd_data[3:0];
            cfg.btype     <= cmd_data[7:4];
            cfg.frames    <= cmd_data[19:8];
        end
    end

    assign cfg.start = start && !cfg.busy && (cfg.frames != '0);

    always_comb begin
        status         = '0;
        status[11:0]   = cfg.frames_done;
        status[27:16]  = 12'(next_addr);
        status[31]     = cfg.busy;
    end

    // accepted start must launch the sequencer on the next cycle
    a_start_launch: assert property (@(posedge clk) disable iff (!rst_n)
        cfg.start |-> !cfg.busy ##1 cfg.busy);

endmodule

// File: logic/console.sv
module console import acq_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    acq_cfg_if.seq cfg,
    output logic   fs_conv,
    input  logic   fd_conv,
    output logic   fs_tran,
    input  logic   fd_tran,
    output logic   done
);

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state           <= SEQ_IDLE;
            fs_conv         <= 1'b0;
            fs_tran         <= 1'b0;
            done            <= 1'b0;
            cfg.busy        <= 1'b0;
            cfg.frames_done <= '0;
        end else begin
            fs_conv <= 1'b0;    // strobes default low
            fs_tran <= 1'b0;
            done    <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cfg.start) begin
                        state           <= SEQ_CONV;
                        fs_conv         <= 1'b1;
                        cfg.busy        <= 1'b1;
                        cfg.frames_done <= '0;
                    end
                end
                SEQ_CONV: begin
                    if (fd_conv) begin
                        state   <= SEQ_TRAN;
                        fs_tran <= 1'b1;
                    end
                end
                SEQ_TRAN: begin
                    if (fd_tran) begin
                        state           <= SEQ_NEXT;
                        cfg.frames_done <= cfg.frames_done + 1'b1;
                    end
                end
                SEQ_NEXT: begin
                    if (cfg.frames_done == cfg.frames) begin
                        state    <= SEQ_IDLE;
                        done     <= 1'b1;   // same edge as busy falling
                        cfg.busy <= 1'b0;
                    end else begin
                        state   <= SEQ_CONV;
                        fs_conv <= 1'b1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        !(fs_conv && fs_tran));

endmodule

// File: logic/adc_spi.sv
module adc_spi import acq_pkg::*; #(
    parameter int SCLK_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               fs_conv,
    output logic               fd_conv,
    output lane_samples_t      samples,
    output logic               cs_n,
    output logic               sclk,
    input  logic [N_LANES-1:0] miso
);

    localparam int DIV_W = (SCLK_DIV > 1) ? $clog2(SCLK_DIV) : 1;

    logic [DIV_W-1:0] div_cnt;
    logic [4:0]       edge_cnt;     // sclk half periods done
    logic             half_end;
    lane_samples_t    shreg;

    assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));

    // ----------------------------------------------------------------------
    // framing: cs_n low for 16 sclk periods
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cs_n     <= 1'b1;
            sclk     <= 1'b0;
            fd_conv  <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
        end else begin
            fd_conv <= 1'b0;
            if (cs_n) begin
                div_cnt  <= '0;
                edge_cnt <= '0;
                if (fs_conv) begin
                    cs_n <= 1'b0;
                end
            end else if (half_end) begin
                div_cnt  <= '0;
                sclk     <= ~sclk;
                edge_cnt <= edge_cnt + 5'd1;
                if (edge_cnt == 5'd31) begin    // last falling edge
                    cs_n    <= 1'b1;
                    fd_conv <= 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // lane shifters, msb first
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!cs_n && half_end) begin
            if (!sclk) begin    // rising sclk
                for (int i = 0; i < N_LANES; i++) begin
                    shreg[i] <= {shreg[i][SAMPLE_W-2:0], miso[i]};
                end
            end
            if (edge_cnt == 5'd31) begin
                samples <= shreg;
            end
        end
    end

    a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cs_n |-> !sclk);

    // conversion length as seen by the sequencer
    a_conv_len: assert property (@(posedge clk) disable iff (!rst_n)
        (fs_conv && cs_n) |-> ##(32 * SCLK_DIV + 1) fd_conv);

endmodule

// File: logic/data_make.sv
module data_make import acq_pkg::*; #(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic              rst_n,
    acq_cfg_if.pack           cfg,
    input  logic              fs_tran,
    output logic              fd_tran,
    input  lane_samples_t     samples,
    output logic [RAM_AW-1:0] ram_wa,
    output byte_t             ram_wd,
    output logic              ram_we
);

    logic       active;
    logic       lo_phase;   // next byte is a low half
    chan_mask_t rem_mask;   // lanes still to write
    lane_idx_t  cur_lane;
    lane_idx_t  nxt_lane;
    frame_cnt_t frame_idx;
    logic       emit;
    logic       emit_hi;
    byte_t      emit_byte;

    function automatic lane_idx_t low_lane(input chan_mask_t m);
        lane_idx_t idx;
        idx = '0;
        for (int i = N_LANES - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = lane_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign nxt_lane = low_lane(rem_mask);
    assign emit_hi  = active && !lo_phase && (rem_mask != '0);

    always_comb begin
        emit      = 1'b0;
        emit_byte = samples[cur_lane][7:0];
        if (fs_tran) begin
            emit      = 1'b1;
            emit_byte = {cfg.btype, frame_idx[3:0]};    // header
        end else if (active && lo_phase) begin
            emit = 1'b1;
        end else if (emit_hi) begin
            emit      = 1'b1;
            emit_byte = samples[nxt_lane][15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active     <= 1'b0;
            lo_phase   <= 1'b0;
            rem_mask   <= '0;
            fd_tran    <= 1'b0;
            ram_we     <= 1'b0;
            frame_idx  <= '0;
            cfg.wr_ptr <= '0;
        end else begin
            fd_tran <= 1'b0;
            ram_we  <= emit;
            if (cfg.start) begin    // console leaving idle
                frame_idx  <= '0;
                cfg.wr_ptr <= '0;
            end else begin
                if (emit) begin
                    cfg.wr_ptr <= cfg.wr_ptr + 1'b1;
                end
                if (fs_tran) begin
                    active    <= 1'b1;
                    lo_phase  <= 1'b0;
                    rem_mask  <= cfg.chan_mask;
                    frame_idx <= frame_idx + 1'b1;
                end else if (active && lo_phase) begin
                    lo_phase <= 1'b0;
                end else if (emit_hi) begin
                    lo_phase           <= 1'b1;
                    rem_mask[nxt_lane] <= 1'b0;
                end else if (active) begin
                    active  <= 1'b0;
                    fd_tran <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            ram_wa <= cfg.wr_ptr;
            ram_wd <= emit_byte;
        end
        if (emit_hi && !fs_tran) begin
            cur_lane <= nxt_lane;
        end
    end

    // wr_ptr already points past ram_wa here, zero means it wrapped
    a_no_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |-> cfg.wr_ptr != '0);

endmodule

// File: logic/ram_data.sv
module ram_data import acq_pkg::*; #(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic [RAM_AW-1:0] wa,
    input  byte_t             wd,
    input  logic              we,
    input  logic [RAM_AW-1:0] ra,
    output byte_t             rd
);

    byte_t mem [2**RAM_AW];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wa] <= wd;
        end
        rd <= mem[ra];  // one cycle read latency
    end

endmodule

// File: logic/acq_top.sv
module acq_top import acq_pkg::*; #(
    parameter int RAM_AW   = 12,
    parameter int SCLK_DIV = 2
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               cmd_wr,
    input  cmd_word_t          cmd_data,
    input  logic               start,
    output logic               busy,
    output logic               done,
    output stat_word_t         status,

    input  logic [RAM_AW-1:0]  rd_addr,
    output byte_t              rd_data,

    output logic               adc_cs_n,
    output logic               adc_sclk,
    input  logic [N_LANES-1:0] adc_miso
);

    // ----------------------------------------------------------------------
    // control strobes and data path
    // ----------------------------------------------------------------------
    logic fs_conv, fd_conv;
    logic fs_tran, fd_tran;

    lane_samples_t     samples;
    logic [RAM_AW-1:0] ram_wa;
    byte_t             ram_wd;
    logic              ram_we;

    acq_cfg_if #(.RAM_AW(RAM_AW)) cfg_if ();

    assign busy = cfg_if.busy;

    cmd_regs #(.RAM_AW(RAM_AW))
    cmd_regs_dut(
        .clk(clk),
        .rst_n(rst_n),
        .cmd_wr(cmd_wr),
        .cmd_data(cmd_data),
        .start(start),
        .status(status),
        .cfg(cfg_if.regs)
    );

    console
    console_dut(
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg_if.seq),
        .fs_conv(fs_conv),
        .fd_conv(fd_conv),
        .fs_tran(fs_tran),
        .fd_tran(fd_tran),
        .done(done)
    );

    adc_spi #(.SCLK_DIV(SCLK_DIV))
    adc_spi_dut(
        .clk(clk),
        .rst_n(rst_n),
        .fs_conv(fs_conv),
        .fd_conv(fd_conv),
        .samples(samples),
        .cs_n(adc_cs_n),
        .sclk(adc_sclk),
        .miso(adc_miso)
    );

    data_make #(.RAM_AW(RAM_AW))
    data_make_dut(
        .clk(clk),
        .rst_n(rst_n),
        .cfg(cfg_if.pack),
        .fs_tran(fs_tran),
        .fd_tran(fd_tran),
        .samples(samples),
        .ram_wa(ram_wa),
        .ram_wd(ram_wd),
        .ram_we(ram_we)
    );

    ram_data #(.RAM_AW(RAM_AW))
    ram_data_dut(
        .clk(clk),
        .wa(ram_wa),
        .wd(ram_wd),
        .we(ram_we),
        .ra(rd_addr),
        .rd(rd_data)
    );

endmodule

// File: dv/adc_lane_model.sv
module adc_lane_model import acq_pkg::*; (
    input  logic               cs_n,
    input  logic               sclk,
    input  lane_samples_t      words,
    output logic [N_LANES-1:0] miso,
    output int                 conv_cnt,
    output int                 framing_errs
);

    lane_samples_t shreg;
    int            rises;

    // one pass per cs_n low window, next bit goes out on falling sclk
    initial begin
        miso         = '0;
        conv_cnt     = 0;
        framing_errs = 0;
        shreg        = '0;
        rises        = 0;
        forever begin
            @(negedge cs_n);
            shreg = words;      // words latched as the conversion opens
            rises = 0;
            for (int i = 0; i < N_LANES; i++) begin
                miso[i] = shreg[i][SAMPLE_W-1];
            end
            while (cs_n === 1'b0) begin
                @(sclk or cs_n);
                if (cs_n === 1'b0 && sclk === 1'b1) begin
                    rises++;
                end else if (cs_n === 1'b0 && sclk === 1'b0) begin
                    for (int i = 0; i < N_LANES; i++) begin
                        shreg[i] = shreg[i] << 1;
                        miso[i]  = shreg[i][SAMPLE_W-1];
                    end
                end
            end
            conv_cnt++;
            if (rises != 16) begin
                framing_errs++;
                $display("framing error: conversion %0d had %0d rising sclk edges %s",
                         conv_cnt, rises, "while cs_n was low instead of 16");
            end
        end
    end

endmodule

// File: dv/acq_tb.sv
module acq_tb import acq_pkg::*; ();

    localparam int RAM_AW       = 12;
    localparam int SCLK_DIV     = 2;
    localparam int MAX_FRAMES   = 8;
    localparam int FRAME_CYCLES = 32 * SCLK_DIV + 12;
    localparam int WATCH_FRAMES = 1 + 20 * MAX_FRAMES + 6 + 3 + 4;
    localparam int WATCH_CYCLES = WATCH_FRAMES * FRAME_CYCLES + 20000;  // margin for readback

    logic               clk;
    logic               rst_n;
    logic               cmd_wr;
    cmd_word_t          cmd_data;
    logic               start;
    logic               busy;
    logic               done;
    stat_word_t         status;
    logic [RAM_AW-1:0]  rd_addr;
    byte_t              rd_data;
    logic               adc_cs_n;
    logic               adc_sclk;
    logic [N_LANES-1:0] adc_miso;

    lane_samples_t lane_words;
    lane_samples_t frame_words [0:MAX_FRAMES];
    byte_t         exp_mem [$];     // expected ram image of one run
    int            conv_cnt;
    int            framing_errs;

    integer seed = 32'hf6ce_1453;
    int     check_cnt;
    int     err_cnt;
    int     test_cnt;
    int     test_fail_cnt;

    acq_top #(.RAM_AW(RAM_AW), .SCLK_DIV(SCLK_DIV)) acq_top_i (
        .clk(clk),
        .rst_n(rst_n),
        .cmd_wr(cmd_wr),
        .cmd_data(cmd_data),
        .start(start),
        .busy(busy),
        .done(done),
        .status(status),
        .rd_addr(rd_addr),
        .rd_data(rd_data),
        .adc_cs_n(adc_cs_n),
        .adc_sclk(adc_sclk),
        .adc_miso(adc_miso)
    );

    adc_lane_model lane_model_i (
        .cs_n(adc_cs_n),
        .sclk(adc_sclk),
        .words(lane_words),
        .miso(adc_miso),
        .conv_cnt(conv_cnt),
        .framing_errs(framing_errs)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCH_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", WATCH_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------------------------------------
    // checking and reporting
    // ----------------------------------------------------------------------
    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: passed", name);
        end else begin
            test_fail_cnt++;
            $display("test %s: failed with %0d mismatches", name, err_cnt - errs_before);
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model and run sequence
    // ----------------------------------------------------------------------
    task automatic build_expected(input chan_mask_t mask, input btype_t bt, input int frames);
        exp_mem.delete();
        for (int f = 0; f < frames; f++) begin
            exp_mem.push_back({bt, 4'(f)});     // header
            for (int l = 0; l < N_LANES; l++) begin
                if (mask[l]) begin
                    exp_mem.push_back(frame_words[f][l][15:8]);
                    exp_mem.push_back(frame_words[f][l][7:0]);
                end
            end
        end
    endtask

    task automatic read_back(input string name);
        for (int i = 0; i < exp_mem.size(); i++) begin
            rd_addr <= RAM_AW'(i);
            @(posedge clk);
            @(posedge clk);     // registered read
            compare($sformatf("%s ram[%0d]", name, i), 32'(exp_mem[i]), 32'(rd_data));
        end
    endtask

    task automatic run_acquisition(input string name, input chan_mask_t mask, input btype_t bt,
                                   input int frames, input bit poke);
        cmd_word_t cmd;
        int        conv_base;
        int        pulses;
        bit        seen_done;
        for (int f = 0; f < frames; f++) begin
            for (int l = 0; l < N_LANES; l++) begin
                frame_words[f][l] = 16'($random(seed));
            end
        end
        build_expected(mask, bt, frames);
        conv_base = conv_cnt;
        cmd = $random(seed);    // upper bits are don't care
        cmd[19:0] = {12'(frames), bt, mask};
        lane_words <= frame_words[0];
        cmd_wr     <= 1'b1;
        cmd_data   <= cmd;
        @(posedge clk);
        cmd_wr <= 1'b0;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        compare({name, " busy after start"}, 32'd1, 32'(busy));
        for (int f = 0; f < frames; f++) begin
            @(posedge adc_cs_n);    // conversion closed, hand over next words
            lane_words <= frame_words[f+1];
            if (poke && f == 0 && frames > 1) begin
                @(negedge adc_cs_n);    // frame 0 already in ram
                @(posedge clk);
                cmd_wr   <= 1'b1;
                cmd_data <= $random(seed);
                start    <= 1'b1;
                @(posedge clk);
                cmd_wr <= 1'b0;
                start  <= 1'b0;
            end
        end
        pulses    = 0;
        seen_done = 1'b0;
        while (!seen_done) begin
            @(posedge clk);
            if (done) begin
                seen_done = 1'b1;
                pulses++;
                compare({name, " busy with done"}, 32'd0, 32'(busy));
            end
        end
        repeat (4) begin
            @(posedge clk);
            if (done) begin
                pulses++;
            end
        end
        compare({name, " done pulses"}, 32'd1, 32'(pulses));
        compare({name, " conversions"}, 32'(frames), 32'(conv_cnt - conv_base));
        compare({name, " status"}, {1'b0, 3'b0, 12'(exp_mem.size()), 4'b0, 12'(frames)},
                status);
        read_back(name);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    initial begin
        int         errs;
        int         conv_base;
        int         frame_err_base;
        chan_mask_t mask;
        btype_t     bt;
        int         frames;
        rst_n         = 1'b0;
        cmd_wr        = 1'b0;
        cmd_data      = '0;
        start         = 1'b0;
        rd_addr       = '0;
        lane_words    = '0;
        check_cnt     = 0;
        err_cnt       = 0;
        test_cnt      = 0;
        test_fail_cnt = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        errs = err_cnt;
        compare("reset busy", 32'd0, 32'(busy));
        compare("reset done", 32'd0, 32'(done));
        compare("reset cs_n", 32'd1, 32'(adc_cs_n));
        compare("reset sclk", 32'd0, 32'(adc_sclk));
        compare("reset status", 32'd0, status);
        report_test("reset_state", errs);

        errs = err_cnt;
        run_acquisition("single_run", 4'b1111, 4'($random(seed)), 1, 1'b0);
        report_test("single_run", errs);

        errs = err_cnt;
        for (int k = 0; k < 20; k++) begin
            mask   = 4'($random(seed));
            bt     = 4'($random(seed));
            frames = 1 + ($random(seed) & 7);
            run_acquisition($sformatf("random_run_%0d", k), mask, bt, frames, 1'b0);
        end
        report_test("random_runs", errs);

        errs = err_cnt;
        run_acquisition("mask_zero", 4'b0000, 4'($random(seed)), 6, 1'b0);
        compare("mask_zero next address", 32'd6, 32'(status[27:16]));
        report_test("mask_zero", errs);

        errs = err_cnt;
        run_acquisition("busy_guard", 4'($random(seed)), 4'($random(seed)), 3, 1'b1);
        report_test("busy_guard", errs);

        errs           = err_cnt;
        conv_base      = conv_cnt;
        frame_err_base = framing_errs;
        run_acquisition("framing", 4'($random(seed)), 4'($random(seed)), 4, 1'b0);
        compare("framing conversions", 32'd4, 32'(conv_cnt - conv_base));
        compare("framing errors", 32'(frame_err_base), 32'(framing_errs));
        report_test("framing", errs);

        $display("%0d tests, %0d failed, %0d checks, %0d mismatches, %0d framing errors",
                 test_cnt, test_fail_cnt, check_cnt, err_cnt, framing_errs);
        if (err_cnt == 0 && framing_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sources.f
logic/acq_pkg.sv
logic/acq_cfg_if.sv
logic/cmd_regs.sv
logic/console.sv
logic/adc_spi.sv
logic/data_make.sv
logic/ram_data.sv
logic/acq_top.sv
dv/adc_lane_model.sv
dv/acq_tb.sv

// File: Makefile
TOP = acq_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir
